//--- osc_wave_pkg.sv
// Waveform types
`default_nettype none

package osc_wave_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Default sample resolution, same as DATA_WIDTH at the top level
  localparam int SAMPLE_WIDTH = 12;

  // Phase accumulator resolution, same as COUNTER_WIDTH at the top level
  localparam int PHASE_WIDTH = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Signed two's complement audio sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // Unsigned phase, wraps modulo 2^PHASE_WIDTH
  typedef logic [PHASE_WIDTH-1:0] phase_t;

  // Waveform enables
  // Bit 0 square, bit 1 sawtooth, bit 2 triangle
  typedef logic [2:0] wave_mask_t;

  // One sample towards the consumer
  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_out_t;

endpackage

`default_nettype wire

//--- osc_cfg_pkg.sv
// Oscillator register map
`default_nettype none

package osc_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register port types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0]  cfg_addr_t;
  typedef logic [15:0] cfg_data_t;

  // Counter-width configuration value (period, duty)
  typedef logic [15:0] cfg_count_t;

  // Right shift applied to one waveform in the mixer
  typedef logic [1:0] atten_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // CTRL: bit 0 enable, bits 3:1 waveform mask
  localparam cfg_addr_t ADDR_CTRL       = 4'd0;
  // Square period in samples
  localparam cfg_addr_t ADDR_SQ_PERIOD  = 4'd1;
  // Sample index at which the square drops low
  localparam cfg_addr_t ADDR_SQ_DUTY    = 4'd2;
  // Phase increment per sample
  localparam cfg_addr_t ADDR_PHASE_STEP = 4'd3;
  // ATTEN: bits 1:0 square, 3:2 sawtooth, 5:4 triangle
  localparam cfg_addr_t ADDR_ATTEN      = 4'd4;

  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_MASK_LSB   = 1;

  // Register write, accepted whenever valid is high
  typedef struct packed {
    logic      valid;
    cfg_addr_t addr;
    cfg_data_t data;
  } cfg_write_t;

  // Shift per waveform, square in the low bits as in the ATTEN register
  typedef struct packed {
    atten_t triangle;
    atten_t saw;
    atten_t square;
  } atten_cfg_t;

  // Full configuration seen by the datapath
  typedef struct packed {
    logic                    enable;
    osc_wave_pkg::wave_mask_t mask;
    cfg_count_t              sq_period;
    cfg_count_t              sq_duty;
    osc_wave_pkg::phase_t    phase_step;
    atten_cfg_t              atten;
  } osc_cfg_t;

endpackage

`default_nettype wire

//--- osc_regs.sv
// Configuration registers
`timescale 1ns/1ns
`default_nettype none

module osc_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  osc_cfg_pkg::cfg_write_t cfg_write,
  output osc_cfg_pkg::osc_cfg_t   cfg
);

  import osc_cfg_pkg::*;
  import osc_wave_pkg::*;

  // Reset values of the square timing
  localparam cfg_count_t PERIOD_RESET = 16'd16;
  localparam cfg_count_t DUTY_RESET   = 16'd8;

  // One register per address
  logic       enable_q;
  wave_mask_t mask_q;
  cfg_count_t period_q;
  cfg_count_t duty_q;
  phase_t     phase_step_q;
  atten_cfg_t atten_q;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q     <= 1'b0;
      mask_q       <= '0;
      period_q     <= PERIOD_RESET;
      duty_q       <= DUTY_RESET;
      phase_step_q <= '0;
      atten_q      <= '0;
    end else if (cfg_write.valid) begin
      // Unmapped addresses are ignored
      case (cfg_write.addr)
        ADDR_CTRL: begin
          enable_q <= cfg_write.data[CTRL_ENABLE_BIT];
          mask_q   <= cfg_write.data[CTRL_MASK_LSB +: 3];
        end
        ADDR_SQ_PERIOD:  period_q     <= cfg_write.data;
        ADDR_SQ_DUTY:    duty_q       <= cfg_write.data;
        ADDR_PHASE_STEP: phase_step_q <= cfg_write.data;
        // Three 2-bit shifts, square lowest
        ADDR_ATTEN:      atten_q      <= cfg_write.data[5:0];
        default: ;
      endcase
    end
  end

  // Registers straight onto the struct
  assign cfg = '{
    enable:     enable_q,
    mask:       mask_q,
    sq_period:  period_q,
    sq_duty:    duty_q,
    phase_step: phase_step_q,
    atten:      atten_q
  };

endmodule

`default_nettype wire

//--- osc_square.sv
// Square wave oscillator
`timescale 1ns/1ns
`default_nettype none

module osc_square #(
  parameter int DATA_WIDTH    = 12,
  parameter int COUNTER_WIDTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      step,
  input  logic [COUNTER_WIDTH-1:0]  period,
  input  logic [COUNTER_WIDTH-1:0]  duty,
  output osc_wave_pkg::sample_t     square
);

  import osc_wave_pkg::*;

  // Full-scale signed levels
  localparam sample_t SQ_HIGH = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam sample_t SQ_LOW  = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  // Samples since the start of the period
  logic [COUNTER_WIDTH-1:0] count_q;
  sample_t                  square_q;

  // Counter only moves when a sample leaves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q  <= '0;
      square_q <= SQ_HIGH;
    end else if (step) begin
      count_q <= count_q + 1'b1;
      // End of the high part
      if (count_q == duty - 1'b1) begin
        square_q <= SQ_LOW;
      end
      // Period over, restart high; also catches a period shortened on the fly
      if (count_q >= period - 1'b1) begin
        count_q  <= '0;
        square_q <= SQ_HIGH;
      end
    end
  end

  assign square = square_q;

endmodule

`default_nettype wire

//--- osc_phase.sv
// Sawtooth and triangle oscillator
`timescale 1ns/1ns
`default_nettype none

module osc_phase #(
  parameter int DATA_WIDTH    = 12,
  parameter int COUNTER_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  step,
  input  osc_wave_pkg::phase_t  phase_step,
  output osc_wave_pkg::sample_t saw,
  output osc_wave_pkg::sample_t triangle
);

  import osc_wave_pkg::*;

  phase_t phase_q;

  // Phase below the MSB, mirrored in the second half of the cycle
  logic [COUNTER_WIDTH-2:0] fold;

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////////////////////

  // Natural wrap modulo 2^COUNTER_WIDTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
    end else if (step) begin
      phase_q <= phase_q + phase_step;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Waveform shaping
  ////////////////////////////////////////////////////////////////////////////

  // Top bits as offset binary, flip MSB for two's complement
  assign saw = {~phase_q[COUNTER_WIDTH-1], phase_q[COUNTER_WIDTH-2 -: DATA_WIDTH-1]};

  // Rising ramp in the first half, falling in the second
  assign fold = phase_q[COUNTER_WIDTH-1] ? ~phase_q[COUNTER_WIDTH-2:0]
                                         : phase_q[COUNTER_WIDTH-2:0];

  // Same offset binary trick on the folded value
  assign triangle = {~fold[COUNTER_WIDTH-2], fold[COUNTER_WIDTH-3 -: DATA_WIDTH-1]};

endmodule

`default_nettype wire

//--- wave_mixer.sv
// Waveform mixer
`timescale 1ns/1ns
`default_nettype none

module wave_mixer #(
  parameter int DATA_WIDTH = 12
) (
  input  osc_wave_pkg::sample_t    square,
  input  osc_wave_pkg::sample_t    saw,
  input  osc_wave_pkg::sample_t    triangle,
  input  osc_wave_pkg::wave_mask_t mask,
  input  osc_cfg_pkg::atten_cfg_t  atten,
  output osc_wave_pkg::sample_t    mix_sample
);

  import osc_wave_pkg::*;
  import osc_cfg_pkg::*;

  // Two guard bits hold the sum of three full-scale inputs
  localparam int SUM_WIDTH = DATA_WIDTH + 2;

  // Saturation limits, sign extended to the sum width
  localparam logic signed [SUM_WIDTH-1:0] SAT_MAX = {3'b000, {(DATA_WIDTH-1){1'b1}}};
  localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = {3'b111, {(DATA_WIDTH-1){1'b0}}};

  logic signed [SUM_WIDTH-1:0] sq_term;
  logic signed [SUM_WIDTH-1:0] saw_term;
  logic signed [SUM_WIDTH-1:0] tri_term;
  logic signed [SUM_WIDTH-1:0] sum;

  // Sign extend, then arithmetic shift; zero when the waveform is off
  function automatic logic signed [SUM_WIDTH-1:0] attenuate(
    input sample_t s,
    input atten_t  shift,
    input logic    en
  );
    logic signed [SUM_WIDTH-1:0] ext;
    ext = {{2{s[DATA_WIDTH-1]}}, s};
    ext = ext >>> shift;
    return en ? ext : '0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Shift, sum, saturate
  ////////////////////////////////////////////////////////////////////////////

  assign sq_term  = attenuate(square,   atten.square,   mask[0]);
  assign saw_term = attenuate(saw,      atten.saw,      mask[1]);
  assign tri_term = attenuate(triangle, atten.triangle, mask[2]);

  assign sum = sq_term + saw_term + tri_term;

  // Clip to the signed DATA_WIDTH range
  always_comb begin
    if (sum > SAT_MAX) begin
      mix_sample = SAT_MAX[DATA_WIDTH-1:0];
    end else if (sum < SAT_MIN) begin
      mix_sample = SAT_MIN[DATA_WIDTH-1:0];
    end else begin
      mix_sample = sum[DATA_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

//--- sample_credit_tx.sv
// Credit-based sample output
`timescale 1ns/1ns
`default_nettype none

module sample_credit_tx #(
  parameter int CREDITS_INIT = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable,
  input  osc_wave_pkg::sample_t     mix_sample,
  input  logic                      credit_return,
  output logic                      step,
  output osc_wave_pkg::sample_out_t sample_out
);

  import osc_wave_pkg::*;

  // Wide enough to hold CREDITS_INIT itself
  localparam int CNT_WIDTH = $clog2(CREDITS_INIT + 1);

  logic [CNT_WIDTH-1:0] credits_q;
  logic                 send;
  logic                 valid_q;
  sample_t              data_q;

  // Send whenever the consumer has room
  assign send = enable && (credits_q != '0);

  // Oscillators move on the same edge that captures the sample
  assign step = send;

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  // Send and return in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q <= CNT_WIDTH'(CREDITS_INIT);
    end else begin
      case ({send, credit_return})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Single-cycle valid per sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= send;
    end
  end

  // Data only qualified by valid
  always_ff @(posedge clk) begin
    if (send) begin
      data_q <= mix_sample;
    end
  end

  assign sample_out = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

//--- osc_subsystem_top.sv
// Oscillator subsystem top
`timescale 1ns/1ns
`default_nettype none

module osc_subsystem_top #(
  parameter int DATA_WIDTH    = 12,
  parameter int COUNTER_WIDTH = 16,
  parameter int CREDITS_INIT  = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  osc_cfg_pkg::cfg_write_t   cfg_write,
  input  logic                      credit_return,
  output osc_wave_pkg::sample_out_t sample_out
);

  import osc_cfg_pkg::*;
  import osc_wave_pkg::*;

  osc_cfg_t cfg;

  // Advance strobe from the output stage
  logic    step;

  // Combinational waveform path
  sample_t square;
  sample_t saw;
  sample_t triangle;
  sample_t mix_sample;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  osc_regs i_osc_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_write (cfg_write),
    .cfg       (cfg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Oscillators
  ////////////////////////////////////////////////////////////////////////////

  osc_square #(
    .DATA_WIDTH    (DATA_WIDTH),
    .COUNTER_WIDTH (COUNTER_WIDTH)
  ) i_osc_square (
    .clk    (clk),
    .rst_n  (rst_n),
    .step   (step),
    .period (cfg.sq_period),
    .duty   (cfg.sq_duty),
    .square (square)
  );

  osc_phase #(
    .DATA_WIDTH    (DATA_WIDTH),
    .COUNTER_WIDTH (COUNTER_WIDTH)
  ) i_osc_phase (
    .clk        (clk),
    .rst_n      (rst_n),
    .step       (step),
    .phase_step (cfg.phase_step),
    .saw        (saw),
    .triangle   (triangle)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Mix and send
  ////////////////////////////////////////////////////////////////////////////

  wave_mixer #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_wave_mixer (
    .square     (square),
    .saw        (saw),
    .triangle   (triangle),
    .mask       (cfg.mask),
    .atten      (cfg.atten),
    .mix_sample (mix_sample)
  );

  sample_credit_tx #(
    .CREDITS_INIT (CREDITS_INIT)
  ) i_sample_credit_tx (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (cfg.enable),
    .mix_sample    (mix_sample),
    .credit_return (credit_return),
    .step          (step),
    .sample_out    (sample_out)
  );

endmodule

`default_nettype wire

//--- tb_osc_subsystem.sv
// Oscillator subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module tb_osc_subsystem;

  import osc_cfg_pkg::*;
  import osc_wave_pkg::*;

  localparam int    CLK_HALF      = 2;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RESET_CYCLES  = 4;
  localparam int    CREDITS_INIT  = 4;
  // Watchdog budget per expected sample
  localparam int    SAMPLE_CYCLES = 20;
  // Idle window that shows no extra sample follows
  localparam int    QUIET_CYCLES  = 10;
  localparam string DATA_FILE     = "osc_testdata.txt";

  // One parsed command from the data file
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
  } command_t;

  logic        clk;
  logic        rst_n;
  cfg_write_t  cfg_write;
  logic        credit_return;
  sample_out_t sample_out;

  command_t cmd_q[$];
  int       fields[$];
  sample_t  expect_q[$];

  // Expected samples not yet seen
  int     pending;
  // Since the last reset
  int     received_count;
  int     returned_count;
  // Whole run
  int     expect_total;
  int     reset_total;
  int     write_total;
  int     count_total;
  int     watchdog_cycles;
  integer seed;

  osc_subsystem_top #(
    .DATA_WIDTH    (12),
    .COUNTER_WIDTH (16),
    .CREDITS_INIT  (CREDITS_INIT)
  ) i_osc_subsystem_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_write     (cfg_write),
    .credit_return (credit_return),
    .sample_out    (sample_out)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic halt_run();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Data file
  ////////////////////////////////////////////////////////////////////////////

  // Value of one digit, -1 for anything else
  function automatic int digit_value(input byte c);
    if (c >= "0" && c <= "9") return c - "0";
    if (c >= "a" && c <= "f") return c - "a" + 10;
    if (c >= "A" && c <= "F") return c - "A" + 10;
    return -1;
  endfunction

  // Numbers after the command letter, up to a trailing comment
  task automatic parse_fields(input string text, input int base);
    int  i;
    int  value;
    int  digit;
    bit  in_number;
    bit  done;
    byte c;
    fields.delete();
    value     = 0;
    in_number = 1'b0;
    done      = 1'b0;
    for (i = 1; i < text.len(); i++) begin
      c = text.getc(i);
      if (c == "#") done = 1'b1;
      digit = digit_value(c);
      if (!done && digit >= 0 && digit < base) begin
        value     = value * base + digit;
        in_number = 1'b1;
      end else if (in_number) begin
        fields.push_back(value);
        value     = 0;
        in_number = 1'b0;
      end
    end
    if (in_number) fields.push_back(value);
  endtask

  task automatic load_commands();
    integer   fd;
    string    line;
    byte      op;
    command_t cmd;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %s for reading", DATA_FILE);
      halt_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        op        = (line.len() > 0) ? line.getc(0) : "#";
        cmd       = '0;
        cmd.op    = op;
        case (op)
          "W": begin
            parse_fields(line, 16);
            if (fields.size() != 2) begin
              $display("Register write needs an address and data: %s", line);
              halt_run();
            end else begin
              cmd.arg_a = fields[0];
              cmd.arg_b = fields[1];
              cmd_q.push_back(cmd);
              write_total++;
            end
          end
          // One command per expected sample keeps the order
          "E": begin
            parse_fields(line, 16);
            foreach (fields[k]) begin
              cmd.arg_a = fields[k];
              cmd_q.push_back(cmd);
              expect_total++;
            end
          end
          "C", "G", "N": begin
            parse_fields(line, 10);
            if (fields.size() != 1) begin
              $display("Command needs one count: %s", line);
              halt_run();
            end else begin
              cmd.arg_a = fields[0];
              cmd_q.push_back(cmd);
              if (op == "N") count_total++;
            end
          end
          "R": begin
            cmd_q.push_back(cmd);
            reset_total++;
          end
          // Blank and comment lines
          "#", " ", "\n", "\r", "\t": ;
          default: begin
            $display("Unknown command in %s: %s", DATA_FILE, line);
            halt_run();
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
    @(posedge clk);
    #DRIVE_DELAY;
    cfg_write.valid = 1'b1;
    cfg_write.addr  = addr;
    cfg_write.data  = data;
    @(posedge clk);
    #DRIVE_DELAY;
    cfg_write = '0;
  endtask

  // One credit, held for exactly one edge
  task automatic pulse_credit();
    @(posedge clk);
    #DRIVE_DELAY;
    credit_return = 1'b1;
    returned_count++;
    @(posedge clk);
    #DRIVE_DELAY;
    credit_return = 1'b0;
  endtask

  // Consumer hands back a credit only for a sample it has received
  task automatic return_credits(input int n);
    repeat (n) begin
      wait (received_count > returned_count);
      pulse_credit();
    end
  endtask

  task automatic random_credits(input int n);
    int gap;
    repeat (n) begin
      wait (received_count > returned_count);
      gap = $unsigned($random(seed)) % 8;
      repeat (gap) @(posedge clk);
      pulse_credit();
    end
  endtask

  // Stall with no credits left, then count what came out
  task automatic check_quiet_count(input int n);
    int last;
    int idle;
    last = -1;
    idle = 0;
    // Output has settled once the count holds for a whole window
    while (idle < QUIET_CYCLES) begin
      @(posedge clk);
      if (received_count == last) begin
        idle++;
      end else begin
        last = received_count;
        idle = 0;
      end
    end
    compare_count("samples before first credit return", received_count, n);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n          = 1'b0;
    received_count = 0;
    returned_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
  endtask

  task automatic run_commands();
    command_t cmd;
    foreach (cmd_q[i]) begin
      cmd = cmd_q[i];
      case (cmd.op)
        "W": write_reg(cfg_addr_t'(cmd.arg_a), cfg_data_t'(cmd.arg_b));
        "E": begin
          expect_q.push_back(sample_t'(cmd.arg_a));
          pending++;
        end
        "C": return_credits(cmd.arg_a);
        "G": random_credits(cmd.arg_a);
        "N": check_quiet_count(cmd.arg_a);
        "R": begin
          wait (pending == 0);
          apply_reset();
        end
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  // Mid-cycle, valid and data are settled
  always @(negedge clk) begin
    if (rst_n && sample_out.valid) begin
      if (pending == 0) begin
        $display("Sample 0x%h arrived with no expected value left", sample_out.data);
        halt_run();
      end else begin
        compare_sample("sample_out.data", sample_out.data, expect_q.pop_front());
        pending--;
        received_count++;
      end
    end
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, samples stopped arriving", watchdog_cycles);
    halt_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'hbb51d96d;
    rst_n          = 1'b0;
    cfg_write      = '0;
    credit_return  = 1'b0;
    pending        = 0;
    received_count = 0;
    returned_count = 0;
    expect_total   = 0;
    reset_total    = 0;
    write_total    = 0;
    count_total    = 0;
    load_commands();
    // Budget from the length of the command list
    watchdog_cycles = expect_total * SAMPLE_CYCLES
                    + (reset_total + 1) * (RESET_CYCLES + 2)
                    + write_total * 2
                    + (count_total + 1) * QUIET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    run_commands();
    wait (pending == 0);
    // Late extra samples still reach the monitor here
    repeat (QUIET_CYCLES) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- osc_testdata.txt
# Oscillator subsystem stimulus and expected samples, one command per line
# W addr data = register write (hex) | E v v ... = expected samples in order (hex)
# C n = return n credits | G n = n credits with random gaps | N n = sample count (decimal)
# R = reset once every expected sample has arrived

# 1. Square only, period 6, duty 2, no attenuation
W 1 0006
W 2 0002
E 7FF 7FF 800 800 800 800
E 7FF 7FF 800 800 800 800
W 0 0003
C 8

# 2. Sawtooth only, phase step 0x1000, wraps after 16 samples
R
W 3 1000
E 800 900 A00 B00 C00 D00 E00 F00
E 000 100 200 300 400 500 600 700
E 800 900
W 0 0005
C 14

# 3a. Triangle only, phase step 0x2000
R
W 3 2000
E 800 C00 000 400 7FF 3FF FFF BFF
E 800 C00
W 0 0009
C 6

# 3b. Triangle plus sawtooth, shift 1 on each
R
W 3 2000
W 4 0014
E 800 B00 E00 100 3FF 2FF 1FF 0FF
W 0 000D
C 4

# 4. All three at full level, square period 4 duty 2, sums clip
R
W 1 0004
W 2 0002
W 3 2000
E 800 DFF 800 A00 7FF 7FF BFF 9FF
W 0 000F
C 4

# 5. Initial credits only, then the same sawtooth with random credit gaps
R
W 3 1000
E 800 900 A00 B00
W 0 0005
N 4
E C00 D00 E00 F00 000 100 200 300
E 400 500 600 700
G 12

//--- list.f
osc_wave_pkg.sv
osc_cfg_pkg.sv
osc_regs.sv
osc_square.sv
osc_phase.sv
wave_mixer.sv
sample_credit_tx.sv
osc_subsystem_top.sv
tb_osc_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the oscillator subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_osc_subsystem -f list.f \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_osc_subsystem > sim.log 2>&1 || echo "Simulation exited with an error status"

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "No result in sim.log"; exit 1; }
